// ==== files.f ====
src/afu_fabric_pkg.sv
src/flr_rst_ctrl.sv
src/pfvf_rx_router.sv
src/port_pipe_stage.sv
src/pfvf_tx_arbiter.sv
src/afu_fabric_top.sv
verif/tb_afu_fabric.sv

// ==== verif/tb_afu_fabric.sv ====
// Testbench for the fabric with clock, reset, stimulus table, models and compare tasks
`timescale 1ns/1ps

module tb_afu_fabric;

   typedef enum logic [2:0] {
      OP_RX,                                // Send one host beat
      OP_DRAIN,                             // Wait until every expected beat is seen
      OP_FLR_REQ,                           // Raise FLR request
      OP_FLR_DONE,                          // Finish the four-phase handshake
      OP_TX,                                // All ports transmit a short stream
      OP_STALL_ON,                          // Random ready on ports and host
      OP_STALL_OFF
   } t_op;

   typedef struct {
      t_op                      op;
      afu_fabric_pkg::t_pf      pf;
      afu_fabric_pkg::t_vf      vf;
      logic                     vf_active;
      afu_fabric_pkg::t_data    data;
      afu_fabric_pkg::t_port_id port;      // Expected destination port
      logic                     drop;      // Beat must never show up
   } t_row;

   localparam int TX_BEATS = 2;            // Beats each port streams per transmit row

   logic                                                 clk;
   logic                                                 i_arst_n;
   logic                                                 i_rx_valid;
   afu_fabric_pkg::t_data                                i_rx_data;
   afu_fabric_pkg::t_pf                                  i_rx_pf;
   afu_fabric_pkg::t_vf                                  i_rx_vf;
   logic                                                 i_rx_vf_active;
   logic                                                 o_rx_ready;
   afu_fabric_pkg::t_port_mask                           o_port_valid;
   afu_fabric_pkg::t_data [afu_fabric_pkg::NUM_PORTS-1:0] o_port_data;
   afu_fabric_pkg::t_port_mask                           i_port_ready;
   afu_fabric_pkg::t_port_mask                           i_tx_valid;
   afu_fabric_pkg::t_data [afu_fabric_pkg::NUM_PORTS-1:0] i_tx_data;
   afu_fabric_pkg::t_port_mask                           o_tx_ready;
   logic                                                 o_host_valid;
   afu_fabric_pkg::t_data                                o_host_data;
   afu_fabric_pkg::t_port_id                             o_host_port;
   logic                                                 i_host_ready;
   logic                                                 i_flr_req;
   afu_fabric_pkg::t_pf                                  i_flr_pf;
   afu_fabric_pkg::t_vf                                  i_flr_vf;
   logic                                                 i_flr_vf_active;
   logic                                                 o_flr_ack;

   t_row                     rows[$];                    // Stimulus table
   afu_fabric_pkg::t_data    exp_rx[afu_fabric_pkg::NUM_PORTS][$];
   afu_fabric_pkg::t_data    exp_host_data[$];           // Round-robin order
   afu_fabric_pkg::t_port_id exp_host_port[$];
   afu_fabric_pkg::t_port_id model_last = 2'd3;          // No grant yet so port 0 goes first
   logic [31:0]              lcg_state  = 32'hc3b2242d;
   logic                     stall_on;
   int                       cyc = 0;                    // Rising edges seen
   int                       req_seen_cyc;

   afu_fabric_top u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Random readies from the upper LCG bits
   always @(posedge clk)
   begin
      logic [31:0] r;
      #1;
      r            = lcg_next();
      i_port_ready = stall_on ? r[31:28] : '1;
      i_host_ready = stall_on ? r[27] : 1'b1;
   end

   // ------------------------------------------------------------
   // Failure handling and compare tasks
   // ------------------------------------------------------------
   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic give_up_waiting(input string what);
      $display("Timeout at %0t ns: the fabric never got to %s", $time, what);
      abort_run();
   endtask

   task automatic check_data(input afu_fabric_pkg::t_data got, input afu_fabric_pkg::t_data exp,
                             input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_port(input afu_fabric_pkg::t_port_id got,
                             input afu_fabric_pkg::t_port_id exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   // ------------------------------------------------------------
   // Output monitors sampled mid-cycle where handshakes are stable
   // ------------------------------------------------------------
   always @(negedge clk)
   begin
      if (i_arst_n)
      begin
         for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
         begin
            if (o_port_valid[p] && i_port_ready[p])
            begin
               if (exp_rx[p].size() == 0)
               begin
                  $display("Port %0d delivered a beat that should not exist at %0t ns", p, $time);
                  abort_run();
               end
               else
                  check_data(o_port_data[p], exp_rx[p].pop_front(),
                             $sformatf("port %0d receive data", p));
            end
         end
         if (o_host_valid && i_host_ready)
         begin
            if (exp_host_data.size() == 0)
            begin
               $display("Host got a transmit beat that should not exist at %0t ns", $time);
               abort_run();
            end
            else
            begin
               check_data(o_host_data, exp_host_data.pop_front(), "host transmit data");
               check_port(o_host_port, exp_host_port.pop_front(), "host transmit port tag");
            end
         end
      end
   end

   // ------------------------------------------------------------
   // Table building
   // ------------------------------------------------------------
   task automatic add_row(input t_op op, input afu_fabric_pkg::t_pf pf,
                          input afu_fabric_pkg::t_vf vf, input logic va,
                          input afu_fabric_pkg::t_port_id port, input logic drop);
      t_row r;
      r.op        = op;
      r.pf        = pf;
      r.vf        = vf;
      r.vf_active = va;
      r.data      = {lcg_next(), lcg_next()};
      r.port      = port;
      r.drop      = drop;
      rows.push_back(r);
   endtask

   // Function fields of each port as laid out in the routing table
   task automatic add_rx(input afu_fabric_pkg::t_port_id port, input logic drop);
      case (port)
         2'd0:    add_row(OP_RX, 1'b0, 1'b0, 1'b0, port, drop);   // PF0
         2'd1:    add_row(OP_RX, 1'b0, 1'b0, 1'b1, port, drop);   // PF0 VF0
         2'd2:    add_row(OP_RX, 1'b0, 1'b1, 1'b1, port, drop);   // PF0 VF1
         default: add_row(OP_RX, 1'b1, 1'b0, 1'b0, port, drop);   // PF1
      endcase
   endtask

   task automatic add_op(input t_op op);
      add_row(op, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);
   endtask

   task automatic build_table();
      logic [31:0] r;
      // Routing plus a PF1 VF beat with no table entry
      for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
         add_rx(afu_fabric_pkg::t_port_id'(p), 1'b0);
      add_row(OP_RX, 1'b1, 1'b0, 1'b1, 2'd0, 1'b1);
      add_rx(2'd3, 1'b0);
      add_op(OP_DRAIN);
      // Back-pressure with random destinations
      add_op(OP_STALL_ON);
      for (int i = 0; i < 24; i++)
      begin
         r = lcg_next();
         add_rx(r[30:29], 1'b0);
      end
      add_op(OP_DRAIN);
      add_op(OP_STALL_OFF);
      // VF FLR on PF0 VF1 blacks out port 2
      add_row(OP_FLR_REQ, 1'b0, 1'b1, 1'b1, 2'd0, 1'b0);
      add_rx(2'd2, 1'b1);
      add_rx(2'd0, 1'b0);
      add_rx(2'd2, 1'b1);
      add_rx(2'd1, 1'b0);
      add_rx(2'd3, 1'b0);
      add_op(OP_FLR_DONE);
      add_rx(2'd2, 1'b0);
      add_op(OP_DRAIN);
      // PF FLR on PF0 takes ports 0 to 2 down
      add_row(OP_FLR_REQ, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);
      add_rx(2'd0, 1'b1);
      add_rx(2'd1, 1'b1);
      add_rx(2'd3, 1'b0);
      add_rx(2'd2, 1'b1);
      add_rx(2'd3, 1'b0);
      add_op(OP_FLR_DONE);
      for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
         add_rx(afu_fabric_pkg::t_port_id'(p), 1'b0);
      add_op(OP_DRAIN);
      // Transmit merge under host stalls
      add_op(OP_STALL_ON);
      add_op(OP_TX);
      add_op(OP_TX);
      add_op(OP_DRAIN);
      add_op(OP_STALL_OFF);
   endtask

   // ------------------------------------------------------------
   // Row actions enter and leave 1 ns after a rising edge
   // ------------------------------------------------------------
   task automatic send_beat(input t_row r);
      logic accepted;
      accepted       = 1'b0;
      i_rx_valid     = 1'b1;
      i_rx_data      = r.data;
      i_rx_pf        = r.pf;
      i_rx_vf        = r.vf;
      i_rx_vf_active = r.vf_active;
      for (int n = 0; n < 200 && !accepted; n++)
      begin
         @(negedge clk);
         accepted = o_rx_ready;             // Transfers on the coming edge
         if (accepted && !r.drop)
            exp_rx[r.port].push_back(r.data);
         @(posedge clk);
         #1;
      end
      i_rx_valid = 1'b0;
      if (!accepted)
         give_up_waiting("accept a host receive beat");
   endtask

   task automatic drain_all();
      logic empty;
      empty = 1'b0;
      for (int n = 0; n < 400 && !empty; n++)
      begin
         @(posedge clk);
         #1;
         empty = (exp_host_data.size() == 0) && (i_tx_valid == '0);
         for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
            if (exp_rx[p].size() != 0)
               empty = 1'b0;
      end
      if (!empty)
         give_up_waiting("deliver every outstanding beat");
   endtask

   task automatic tx_burst();
      afu_fabric_pkg::t_data      beats[TX_BEATS][afu_fabric_pkg::NUM_PORTS];
      afu_fabric_pkg::t_port_mask fired;
      int                         sent[afu_fabric_pkg::NUM_PORTS];
      int                         idx;
      for (int b = 0; b < TX_BEATS; b++)
         for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
            beats[b][p] = {lcg_next(), lcg_next()};
      // Every port keeps requesting, so grants go lap by lap after the last winner
      idx = int'(model_last);
      for (int b = 0; b < TX_BEATS; b++)
         for (int k = 1; k <= afu_fabric_pkg::NUM_PORTS; k++)
         begin
            idx = (int'(model_last) + k) % afu_fabric_pkg::NUM_PORTS;
            exp_host_data.push_back(beats[b][idx]);
            exp_host_port.push_back(afu_fabric_pkg::t_port_id'(idx));
         end
      model_last = afu_fabric_pkg::t_port_id'(idx);
      for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
      begin
         sent[p]      = 0;
         i_tx_data[p] = beats[0][p];
      end
      i_tx_valid = '1;
      for (int n = 0; n < 200 && i_tx_valid != '0; n++)
      begin
         @(negedge clk);
         fired = o_tx_ready & i_tx_valid;
         @(posedge clk);
         #1;
         // Granted ports move to their next beat or withdraw
         for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
         begin
            if (fired[p])
            begin
               sent[p] = sent[p] + 1;
               if (sent[p] < TX_BEATS)
                  i_tx_data[p] = beats[sent[p]][p];
               else
                  i_tx_valid[p] = 1'b0;
            end
         end
      end
      if (i_tx_valid != '0)
         give_up_waiting("grant every transmit port");
   endtask

   task automatic flr_start(input t_row r);
      i_flr_pf        = r.pf;
      i_flr_vf        = r.vf;
      i_flr_vf_active = r.vf_active;
      i_flr_req       = 1'b1;
      req_seen_cyc    = cyc + 1;            // Controller sees req on the next edge
      @(posedge clk);
      #1;
   endtask

   task automatic flr_finish();
      for (int n = 0; n < 100 && !o_flr_ack; n++)
      begin
         @(posedge clk);
         #1;
      end
      if (!o_flr_ack)
         give_up_waiting("acknowledge the FLR");
      check_bit(logic'((cyc - req_seen_cyc) == afu_fabric_pkg::FLR_HOLD_CYCLES + 2), 1'b1,
                "FLR ack latency matches hold time");
      i_flr_req = 1'b0;
      @(posedge clk);
      #1;
      check_bit(o_flr_ack, 1'b0, "FLR ack one cycle after req drop");
   endtask

   task automatic apply_row(input t_row r);
      case (r.op)
         OP_RX:       send_beat(r);
         OP_DRAIN:    drain_all();
         OP_FLR_REQ:  flr_start(r);
         OP_FLR_DONE: flr_finish();
         OP_TX:       tx_burst();
         OP_STALL_ON: stall_on = 1'b1;
         default:
         begin
            stall_on = 1'b0;
            repeat (2) @(posedge clk);      // Readies settle high
            #1;
         end
      endcase
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial
   begin
      i_arst_n        = 1'b0;
      i_rx_valid      = 1'b0;
      i_rx_data       = '0;
      i_rx_pf         = '0;
      i_rx_vf         = '0;
      i_rx_vf_active  = 1'b0;
      i_port_ready    = '0;
      i_tx_valid      = '0;
      i_tx_data       = '0;
      i_host_ready    = 1'b0;
      i_flr_req       = 1'b0;
      i_flr_pf        = '0;
      i_flr_vf        = '0;
      i_flr_vf_active = 1'b0;
      stall_on        = 1'b0;
      build_table();
      repeat (16) @(posedge clk);
      #1;
      check_bit(o_rx_ready, 1'b0, "o_rx_ready in reset");
      check_bit(|o_port_valid, 1'b0, "o_port_valid in reset");
      check_bit(o_host_valid, 1'b0, "o_host_valid in reset");
      check_bit(|o_tx_ready, 1'b0, "o_tx_ready in reset");
      check_bit(o_flr_ack, 1'b0, "o_flr_ack in reset");
      i_arst_n = 1'b1;
      @(posedge clk);
      #1;
      foreach (rows[i])
         apply_row(rows[i]);
      repeat (20) @(posedge clk);           // Room for any stray beat to show up
      $display("No errors");
      $finish;
   end

endmodule

// ==== src/afu_fabric_top.sv ====
// Fabric top, FLR controller, receive router, per-port pipe stages, transmit arbiter
`timescale 1ns/1ps

module afu_fabric_top (
   input  logic                                                 clk,
   input  logic                                                 i_arst_n,
   // Host receive
   input  logic                                                 i_rx_valid,
   input  afu_fabric_pkg::t_data                                i_rx_data,
   input  afu_fabric_pkg::t_pf                                  i_rx_pf,
   input  afu_fabric_pkg::t_vf                                  i_rx_vf,
   input  logic                                                 i_rx_vf_active,
   output logic                                                 o_rx_ready,
   // Port receive
   output afu_fabric_pkg::t_port_mask                           o_port_valid,
   output afu_fabric_pkg::t_data [afu_fabric_pkg::NUM_PORTS-1:0] o_port_data,
   input  afu_fabric_pkg::t_port_mask                           i_port_ready,
   // Port transmit
   input  afu_fabric_pkg::t_port_mask                           i_tx_valid,
   input  afu_fabric_pkg::t_data [afu_fabric_pkg::NUM_PORTS-1:0] i_tx_data,
   output afu_fabric_pkg::t_port_mask                           o_tx_ready,
   // Host transmit
   output logic                                                 o_host_valid,
   output afu_fabric_pkg::t_data                                o_host_data,
   output afu_fabric_pkg::t_port_id                             o_host_port,
   input  logic                                                 i_host_ready,
   // FLR
   input  logic                                                 i_flr_req,
   input  afu_fabric_pkg::t_pf                                  i_flr_pf,
   input  afu_fabric_pkg::t_vf                                  i_flr_vf,
   input  logic                                                 i_flr_vf_active,
   output logic                                                 o_flr_ack
);

   afu_fabric_pkg::t_port_mask port_rst_n;     // Per-port reset, FLR and system
   afu_fabric_pkg::t_port_mask rt_valid;       // Router to pipe stages
   afu_fabric_pkg::t_data      rt_data;
   afu_fabric_pkg::t_port_mask stage_ready;    // Pipe stages back to router

   // ------------------------------------------------------------
   // Reset and receive routing
   // ------------------------------------------------------------
   flr_rst_ctrl u_flr_rst_ctrl (
      .clk, .i_arst_n, .i_flr_req, .i_flr_pf, .i_flr_vf, .i_flr_vf_active,
      .o_flr_ack, .o_port_rst_n (port_rst_n)
   );

   pfvf_rx_router u_rx_router (
      .clk, .i_arst_n, .i_rx_valid, .i_rx_data, .i_rx_pf, .i_rx_vf, .i_rx_vf_active,
      .i_port_ready (stage_ready), .o_rx_ready,
      .o_port_valid (rt_valid),    .o_port_data (rt_data)
   );

   for (genvar p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
   begin : g_port
      port_pipe_stage u_pipe (
         .clk, .i_arst_n,
         .i_port_rst_n (port_rst_n[p]),
         .i_valid (rt_valid[p]),     .i_data (rt_data),   .o_ready (stage_ready[p]),
         .o_valid (o_port_valid[p]), .o_data (o_port_data[p]),
         .i_ready (i_port_ready[p])
      );
   end

   // Transmit merge toward the host
   pfvf_tx_arbiter u_tx_arbiter (
      .clk, .i_arst_n, .i_port_rst_n (port_rst_n), .i_tx_valid, .i_tx_data,
      .i_host_ready, .o_tx_ready, .o_host_valid, .o_host_data, .o_host_port
   );

endmodule

// ==== src/pfvf_tx_arbiter.sv ====
// Round-robin merge of port transmit beats to the host, tagged with port index
`timescale 1ns/1ps

module pfvf_tx_arbiter (
   input  logic                                                 clk,
   input  logic                                                 i_arst_n,
   input  afu_fabric_pkg::t_port_mask                           i_port_rst_n,
   input  afu_fabric_pkg::t_port_mask                           i_tx_valid,
   input  afu_fabric_pkg::t_data [afu_fabric_pkg::NUM_PORTS-1:0] i_tx_data,
   input  logic                                                 i_host_ready,
   output afu_fabric_pkg::t_port_mask                           o_tx_ready,
   output logic                                                 o_host_valid,
   output afu_fabric_pkg::t_data                                o_host_data,
   output afu_fabric_pkg::t_port_id                             o_host_port
);

   afu_fabric_pkg::t_port_mask req;           // Requests from ports out of reset
   afu_fabric_pkg::t_port_id   last_gnt;      // Most recent winner
   afu_fabric_pkg::t_port_id   gnt_idx;
   logic                       gnt_valid;
   logic                       load_en;       // Output register can take a beat
   logic                       tx_fire;

   assign req     = i_tx_valid & i_port_rst_n;
   assign load_en = !o_host_valid || i_host_ready;
   assign tx_fire = gnt_valid && load_en;

   // ------------------------------------------------------------
   // Grant search, starting one past the last winner
   // ------------------------------------------------------------
   always_comb
   begin
      int idx;
      gnt_valid = 1'b0;
      gnt_idx   = last_gnt;
      for (int k = 1; k <= afu_fabric_pkg::NUM_PORTS; k++)
      begin
         idx = (int'(last_gnt) + k) % afu_fabric_pkg::NUM_PORTS;
         if (!gnt_valid && req[idx])
         begin
            gnt_valid = 1'b1;
            gnt_idx   = afu_fabric_pkg::t_port_id'(idx);
         end
      end
      // Ready goes only to the winner
      o_tx_ready = '0;
      if (tx_fire)
         o_tx_ready[gnt_idx] = 1'b1;
   end

   // ------------------------------------------------------------
   // Host output register
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         o_host_valid <= 1'b0;
         last_gnt     <= afu_fabric_pkg::t_port_id'(afu_fabric_pkg::NUM_PORTS - 1); // Port 0 first
      end
      else if (tx_fire)
      begin
         o_host_valid <= 1'b1;
         last_gnt     <= gnt_idx;
      end
      else if (i_host_ready)
         o_host_valid <= 1'b0;                // Drained with nothing behind it
   end

   always_ff @(posedge clk)
   begin
      if (tx_fire)
      begin
         o_host_data <= i_tx_data[gnt_idx];
         o_host_port <= gnt_idx;              // Tag beat with its source port
      end
   end

endmodule

// ==== src/port_pipe_stage.sv ====
// Two-entry skid buffer for one port, flushed while the port is in reset
`timescale 1ns/1ps

module port_pipe_stage (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_port_rst_n,  // FLR or system reset of this port
   input  logic                  i_valid,
   input  afu_fabric_pkg::t_data i_data,
   input  logic                  i_ready,
   output logic                  o_ready,
   output logic                  o_valid,
   output afu_fabric_pkg::t_data o_data
);

   logic                  skid_valid;          // Second entry in use
   afu_fabric_pkg::t_data skid_data;
   logic                  in_fire;
   logic                  main_free;           // Output entry can load this cycle

   // Ready comes straight from a flop, port reset swallows beats
   assign o_ready   = !skid_valid || !i_port_rst_n;
   assign in_fire   = i_valid && o_ready;
   assign main_free = !o_valid || i_ready;

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         o_valid    <= 1'b0;
         skid_valid <= 1'b0;
      end
      else if (!i_port_rst_n)
      begin
         o_valid    <= 1'b0;                   // Flush both entries
         skid_valid <= 1'b0;
      end
      else if (main_free)
      begin
         o_valid    <= skid_valid || in_fire;  // Skid entry goes first
         skid_valid <= 1'b0;
      end
      else if (in_fire)
         skid_valid <= 1'b1;                   // Output stalled, park the beat
   end

   always_ff @(posedge clk)
   begin
      if (main_free)
         o_data <= skid_valid ? skid_data : i_data;
      if (!main_free && in_fire)
         skid_data <= i_data;
   end

endmodule

// ==== src/pfvf_rx_router.sv ====
// Host receive router, PF/VF table lookup into a one-deep output register
`timescale 1ns/1ps

module pfvf_rx_router (
   input  logic                       clk,
   input  logic                       i_arst_n,
   input  logic                       i_rx_valid,
   input  afu_fabric_pkg::t_data      i_rx_data,
   input  afu_fabric_pkg::t_pf        i_rx_pf,
   input  afu_fabric_pkg::t_vf        i_rx_vf,
   input  logic                       i_rx_vf_active,
   input  afu_fabric_pkg::t_port_mask i_port_ready,     // From the pipe stages
   output logic                       o_rx_ready,
   output afu_fabric_pkg::t_port_mask o_port_valid,     // At most one bit set
   output afu_fabric_pkg::t_data      o_port_data       // Shared by all ports
);

   afu_fabric_pkg::t_port_mask hit_mask;                // Table match for this beat
   logic                       active;                  // Out of reset for a cycle
   logic                       drain;                   // Held beat leaves this cycle
   logic                       rx_fire;

   // ------------------------------------------------------------
   // Table lookup
   // ------------------------------------------------------------
   always_comb
   begin
      for (int p = 0; p < afu_fabric_pkg::NUM_PORTS; p++)
      begin
         hit_mask[p] = (i_rx_pf == afu_fabric_pkg::PORT_PF[p]) &&
                       (i_rx_vf_active == afu_fabric_pkg::PORT_VF_ACTIVE[p]) &&
                       (!afu_fabric_pkg::PORT_VF_ACTIVE[p] ||
                        (i_rx_vf == afu_fabric_pkg::PORT_VF[p]));
      end
   end

   // Take a new beat when the register is empty or emptying now
   assign drain      = |(o_port_valid & i_port_ready);
   assign o_rx_ready = active && ((o_port_valid == '0) || drain);
   assign rx_fire    = i_rx_valid && o_rx_ready;

   // ------------------------------------------------------------
   // Output register
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         active       <= 1'b0;
         o_port_valid <= '0;
      end
      else
      begin
         active <= 1'b1;
         if (rx_fire)
            o_port_valid <= hit_mask;          // No match leaves it empty, beat dropped
         else if (drain)
            o_port_valid <= '0;
      end
   end

   // Payload only moves on a routed beat
   always_ff @(posedge clk)
   begin
      if (rx_fire && (hit_mask != '0))
         o_port_data <= i_rx_data;
   end

endmodule

// ==== src/flr_rst_ctrl.sv ====
// FLR request/ack FSM and registered per-port reset generation
`timescale 1ns/1ps

module flr_rst_ctrl (
   input  logic                       clk,
   input  logic                       i_arst_n,
   input  logic                       i_flr_req,        // Four-phase request
   input  afu_fabric_pkg::t_pf        i_flr_pf,         // Function under FLR
   input  afu_fabric_pkg::t_vf        i_flr_vf,
   input  logic                       i_flr_vf_active,  // High for a VF FLR
   output logic                       o_flr_ack,
   output afu_fabric_pkg::t_port_mask o_port_rst_n      // Active low, per port
);

   afu_fabric_pkg::t_flr_state state;
   logic [$clog2(afu_fabric_pkg::FLR_HOLD_CYCLES+2)-1:0] hold_cnt;

   afu_fabric_pkg::t_pf flr_pf;                 // Latched request fields
   afu_fabric_pkg::t_vf flr_vf;
   logic                flr_vf_active;

   logic                in_flr;                 // Function reset window
   logic [afu_fabric_pkg::NUM_PF-1:0]                                   pf_rst_n;
   logic [afu_fabric_pkg::NUM_PF-1:0][afu_fabric_pkg::NUM_VF-1:0]       vf_rst_n;
   afu_fabric_pkg::t_port_mask                                          func_rst_n;

   // ------------------------------------------------------------
   // Request FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         state         <= afu_fabric_pkg::IDLE;
         hold_cnt      <= '0;
         flr_pf        <= '0;
         flr_vf        <= '0;
         flr_vf_active <= 1'b0;
      end
      else
      begin
         case (state)
            afu_fabric_pkg::IDLE:
            begin
               if (i_flr_req)
               begin
                  state         <= afu_fabric_pkg::HOLD;
                  hold_cnt      <= '0;
                  flr_pf        <= i_flr_pf;    // Fields are stable while req is up
                  flr_vf        <= i_flr_vf;
                  flr_vf_active <= i_flr_vf_active;
               end
            end
            afu_fabric_pkg::HOLD:
            begin
               hold_cnt <= hold_cnt + 1'b1;
               // One extra count lets the registered port reset rise with ack
               if (int'(hold_cnt) == afu_fabric_pkg::FLR_HOLD_CYCLES + 1)
                  state <= afu_fabric_pkg::ACK;
            end
            afu_fabric_pkg::ACK:
            begin
               if (!i_flr_req)                   // Requester finished its side
                  state <= afu_fabric_pkg::IDLE;
            end
            default: state <= afu_fabric_pkg::IDLE;
         endcase
      end
   end

   assign o_flr_ack = (state == afu_fabric_pkg::ACK);
   assign in_flr    = (state == afu_fabric_pkg::HOLD) &&
                      (int'(hold_cnt) <= afu_fabric_pkg::FLR_HOLD_CYCLES);

   // ------------------------------------------------------------
   // Function resets and port mapping
   // ------------------------------------------------------------
   always_comb
   begin
      for (int p = 0; p < afu_fabric_pkg::NUM_PF; p++)
      begin
         pf_rst_n[p] = !(in_flr && !flr_vf_active && (flr_pf == afu_fabric_pkg::t_pf'(p)));
         for (int v = 0; v < afu_fabric_pkg::NUM_VF; v++)
            vf_rst_n[p][v] = !(in_flr && flr_vf_active &&
                               (flr_pf == afu_fabric_pkg::t_pf'(p)) &&
                               (flr_vf == afu_fabric_pkg::t_vf'(v)));
      end
      // PF reset covers its VF ports too, VF reset only counts on VF ports
      for (int n = 0; n < afu_fabric_pkg::NUM_PORTS; n++)
         func_rst_n[n] = pf_rst_n[afu_fabric_pkg::PORT_PF[n]] &
                         (!afu_fabric_pkg::PORT_VF_ACTIVE[n] |
                          vf_rst_n[afu_fabric_pkg::PORT_PF[n]][afu_fabric_pkg::PORT_VF[n]]);
   end

   // System reset clears every port at once
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         o_port_rst_n <= '0;
      else
         o_port_rst_n <= func_rst_n;
   end

endmodule

// ==== src/afu_fabric_pkg.sv ====
// Fabric sizes, port routing table, FLR hold time and shared types
package afu_fabric_pkg;

   // ------------------------------------------------------------
   // Sizes
   // ------------------------------------------------------------
   localparam int DATA_W    = 64;          // Payload bits per beat
   localparam int NUM_PF    = 2;           // Physical functions
   localparam int NUM_VF    = 2;           // VFs behind each PF
   localparam int NUM_PORTS = 4;           // Function ports on the fabric

   // Cycles a function stays in reset before the FLR is acked
   localparam int FLR_HOLD_CYCLES = 8;

   // ------------------------------------------------------------
   // Types
   // ------------------------------------------------------------
   typedef logic [DATA_W-1:0]    t_data;       // Beat payload
   typedef logic [0:0]           t_pf;         // PF number
   typedef logic [0:0]           t_vf;         // VF number within a PF
   typedef logic [1:0]           t_port_id;    // Port index, tags host beats
   typedef logic [NUM_PORTS-1:0] t_port_mask;  // One bit per port

   // FLR controller states
   typedef enum logic [1:0] {
      IDLE,                                 // Waiting for a request
      HOLD,                                 // Function held in reset
      ACK                                   // Ack up, waiting for req to drop
   } t_flr_state;

   // ------------------------------------------------------------
   // Routing table
   //
   //    port | function
   //    -----+----------
   //      0  | PF0
   //      1  | PF0 VF0
   //      2  | PF0 VF1
   //      3  | PF1
   // ------------------------------------------------------------

   // PF owning each port, index 0 is the rightmost entry
   localparam t_pf [NUM_PORTS-1:0] PORT_PF = {
      1'b1,                                 // Port 3
      1'b0,                                 // Port 2
      1'b0,                                 // Port 1
      1'b0                                  // Port 0
   };

   // VF number of each port, only looked at for VF ports
   localparam t_vf [NUM_PORTS-1:0] PORT_VF = {
      1'b0,                                 // Port 3, PF
      1'b1,                                 // Port 2, VF1
      1'b0,                                 // Port 1, VF0
      1'b0                                  // Port 0, PF
   };

   // Set where the port is a VF
   localparam t_port_mask PORT_VF_ACTIVE = 4'b0110;

endpackage
